// ==== src/eth_sma_pkg.sv ====
// shared map and types; FIFO depth must stay at or below 7 to fit the 3-bit count
package eth_sma_pkg;

	// ==========================================================
	// widths and frame constants
	// ==========================================================

	// count and watermark width
	localparam int sma_cnt_w = 3;

	localparam int sma_pre_len = 32;
	localparam logic [1:0] sma_start = 2'b01;
	localparam int sma_frame_len = 64;

	typedef enum logic [1:0]
	{
		sma_op_write = 2'b01,
		sma_op_read  = 2'b10
	} sma_op_e;

	// one command FIFO entry
	typedef struct packed
	{
		sma_op_e     op;
		logic [4:0]  regad;
		logic [15:0] data;
	} sma_cmd_t;

	typedef struct packed
	{
		logic [7:0]           clkdiv;
		logic [4:0]           phyadr;
		// idle mdc periods after a frame
		logic [7:0]           interval;
		logic [sma_cnt_w-1:0] tx_wm;
		logic [sma_cnt_w-1:0] rx_wm;
	} sma_cfg_t;

	// bit 0 is tx_warn
	typedef struct packed
	{
		logic turn_nack;
		logic frame_done;
		logic rx_noempty;
		logic rx_warn;
		logic tx_empty;
		logic tx_warn;
	} sma_int_t;

	// ==========================================================
	// register word offsets
	// ==========================================================
	localparam logic [31:0] reg_ctrl    = 32'h00;
	localparam logic [31:0] reg_cfg     = 32'h04;
	localparam logic [31:0] reg_txd     = 32'h08;
	localparam logic [31:0] reg_rxd     = 32'h0C;
	localparam logic [31:0] reg_stat    = 32'h10;
	localparam logic [31:0] reg_int_en  = 32'h14;
	localparam logic [31:0] reg_int_sta = 32'h18;

endpackage

// ==== src/eth_sma_regs.sv ====
// no wait states; strobes are combinational in the access cycle and act at the next edge
module eth_sma_regs
#(
	parameter int FIFO_DEPTH = 4
)
(
	input  logic                                ahb_hclk,
	input  logic                                ahb_hrstn,
	input  logic [31:0]                         paddr,
	input  logic                                pwrite,
	input  logic                                psel,
	input  logic                                penable,
	input  logic [31:0]                         pwdata,
	output logic [31:0]                         prdata,
	input  logic [eth_sma_pkg::sma_cnt_w-1:0]   tx_cnt,
	input  logic [eth_sma_pkg::sma_cnt_w-1:0]   rx_cnt,
	input  logic                                busy,
	input  logic [15:0]                         rx_rdata,
	input  eth_sma_pkg::sma_int_t               int_sta,
	output logic                                tx_push,
	output eth_sma_pkg::sma_cmd_t               tx_wdata,
	output logic                                rx_pop,
	output logic                                tx_clr,
	output logic                                rx_clr,
	output logic                                logic_clr,
	output eth_sma_pkg::sma_cfg_t               cfg,
	output eth_sma_pkg::sma_int_t               int_en,
	output eth_sma_pkg::sma_int_t               int_clr
);

	import eth_sma_pkg::*;

	logic wr_en;
	logic rd_en;
	logic tx_full;
	logic rx_empty;

	assign wr_en = psel && penable && pwrite;
	assign rd_en = psel && penable && !pwrite;

	assign tx_full  = tx_cnt == sma_cnt_w'(FIFO_DEPTH);
	assign rx_empty = rx_cnt == '0;

	// ==========================================================
	// single cycle strobes
	// ==========================================================
	assign tx_clr    = wr_en && (paddr == reg_ctrl) && pwdata[0];
	assign rx_clr    = wr_en && (paddr == reg_ctrl) && pwdata[1];
	assign logic_clr = wr_en && (paddr == reg_ctrl) && pwdata[2];

	// full command FIFO ignores the write
	assign tx_push  = wr_en && (paddr == reg_txd) && !tx_full;
	assign tx_wdata = sma_cmd_t'(pwdata[22:0]);

	// pop on read, nothing to pop when empty
	assign rx_pop = rd_en && (paddr == reg_rxd) && !rx_empty;

	// write one to clear
	assign int_clr = (wr_en && (paddr == reg_int_sta)) ? sma_int_t'(pwdata[5:0]) : '0;

	// ==========================================================
	// configuration and enables
	// ==========================================================
	always_ff @(posedge ahb_hclk or negedge ahb_hrstn)
	begin
		if (!ahb_hrstn)
		begin
			cfg    <= '0;
			int_en <= '0;
		end
		else if (wr_en)
		begin
			if (paddr == reg_cfg)
			begin
				cfg.clkdiv   <= pwdata[7:0];
				cfg.phyadr   <= pwdata[12:8];
				cfg.interval <= pwdata[23:16];
				cfg.tx_wm    <= pwdata[26:24];
				cfg.rx_wm    <= pwdata[30:28];
			end
			if (paddr == reg_int_en)
				int_en <= sma_int_t'(pwdata[5:0]);
		end
	end

	// read mux
	always_comb
	begin
		prdata = '0;
		if (psel)
		begin
			case (paddr)
				reg_cfg:
				begin
					prdata = {1'b0, cfg.rx_wm, 1'b0, cfg.tx_wm, cfg.interval,
						3'b000, cfg.phyadr, cfg.clkdiv};
				end
				reg_rxd:
				begin
					if (!rx_empty)
						prdata[15:0] = rx_rdata;
				end
				reg_stat:
				begin
					prdata[sma_cnt_w-1:0]   = tx_cnt;
					prdata[4 +: sma_cnt_w]  = rx_cnt;
					prdata[8]               = busy;
				end
				reg_int_en:  prdata[5:0] = int_en;
				reg_int_sta: prdata[5:0] = int_sta;
				default:     prdata = '0;
			endcase
		end
	end

	// a pushed command shows in the count at the next edge
	a_push_counted: assert property (@(posedge ahb_hclk) disable iff (!ahb_hrstn)
		tx_push |=> (tx_cnt != '0));

endmodule

// ==== src/eth_sma_fifo.sv ====
// DEPTH at most 7; push when full is dropped, pop when empty is ignored, rdata shows the head
module eth_sma_fifo
#(
	parameter int DEPTH = 4,
	parameter int WIDTH = 16
)
(
	input  logic                                ahb_hclk,
	input  logic                                ahb_hrstn,
	input  logic                                clr,
	input  logic                                push,
	input  logic                                pop,
	input  logic [WIDTH-1:0]                    wdata,
	output logic [WIDTH-1:0]                    rdata,
	output logic [eth_sma_pkg::sma_cnt_w-1:0]   cnt
);

	import eth_sma_pkg::*;

	localparam int ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [WIDTH-1:0] mem [DEPTH];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic             do_push;
	logic             do_pop;

	// wrap at DEPTH, which need not be a power of two
	function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
		ptr_inc = (p == ptr_w'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign do_push = push && (cnt != sma_cnt_w'(DEPTH));
	assign do_pop  = pop && (cnt != '0);

	always_ff @(posedge ahb_hclk or negedge ahb_hrstn)
	begin
		if (!ahb_hrstn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			cnt    <= '0;
		end
		else if (clr)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			cnt    <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			cnt <= cnt + sma_cnt_w'(do_push) - sma_cnt_w'(do_pop);
		end
	end

	always_ff @(posedge ahb_hclk)
	begin
		if (do_push)
			mem[wr_ptr] <= wdata;
	end

	assign rdata = mem[rd_ptr];

	a_cnt_bound: assert property (@(posedge ahb_hclk) disable iff (!ahb_hrstn)
		cnt <= sma_cnt_w'(DEPTH));

endmodule

// ==== src/eth_sma_engine.sv ====
// mdc half period is clkdiv+1 clocks; logic_clr aborts at once and the popped entry is lost
module eth_sma_engine
(
	input  logic                                ahb_hclk,
	input  logic                                ahb_hrstn,
	input  eth_sma_pkg::sma_cfg_t               cfg,
	input  logic                                logic_clr,
	input  logic [eth_sma_pkg::sma_cnt_w-1:0]   tx_cnt,
	input  eth_sma_pkg::sma_cmd_t               tx_rdata,
	input  logic                                rx_full,
	input  logic                                eth_mdio_i,
	output logic                                tx_pop,
	output logic                                rx_push,
	output logic [15:0]                         rx_wdata,
	output logic                                busy,
	output logic                                frame_done,
	output logic                                turn_nack,
	output logic                                eth_mdc,
	output logic                                eth_mdc_oen,
	output logic                                eth_mdio_o,
	output logic                                eth_mdio_oen
);

	import eth_sma_pkg::*;

	// bit positions inside the frame
	localparam int ta_bit   = sma_frame_len - 18;
	localparam int data_bit = sma_frame_len - 16;

	logic                     en;
	logic [7:0]               div_cnt;
	logic [8:0]               bit_cnt;
	logic [sma_frame_len-1:0] tx_sr;
	logic [15:0]              rx_sr;
	logic                     is_rd;
	logic                     ta_bad;
	logic                     tick;
	logic                     mdc_rise;
	logic                     mdc_fall;
	logic                     in_frame;
	logic                     last_bit;
	logic                     end_frame;

	// ==========================================================
	// master enable and mdc timing
	// ==========================================================
	assign tx_pop = !en && (tx_cnt != '0) && !logic_clr;

	assign tick     = en && (div_cnt == cfg.clkdiv);
	assign mdc_rise = tick && !eth_mdc;
	assign mdc_fall = tick && eth_mdc;

	assign in_frame  = bit_cnt < 9'(sma_frame_len);
	assign last_bit  = bit_cnt == 9'(sma_frame_len - 1);
	// frame then interval idle periods
	assign end_frame = bit_cnt == 9'(sma_frame_len - 1) + {1'b0, cfg.interval};

	always_ff @(posedge ahb_hclk or negedge ahb_hrstn)
	begin
		if (!ahb_hrstn)
		begin
			en         <= 1'b0;
			div_cnt    <= '0;
			eth_mdc    <= 1'b0;
			bit_cnt    <= '0;
			tx_sr      <= '0;
			is_rd      <= 1'b0;
			ta_bad     <= 1'b0;
			frame_done <= 1'b0;
			turn_nack  <= 1'b0;
			rx_push    <= 1'b0;
		end
		else
		begin
			frame_done <= 1'b0;
			turn_nack  <= 1'b0;
			rx_push    <= 1'b0;
			if (logic_clr)
			begin
				en      <= 1'b0;
				div_cnt <= '0;
				eth_mdc <= 1'b0;
				bit_cnt <= '0;
			end
			else if (tx_pop)
			begin
				en      <= 1'b1;
				div_cnt <= '0;
				eth_mdc <= 1'b0;
				bit_cnt <= '0;
				is_rd   <= tx_rdata.op == sma_op_read;
				ta_bad  <= 1'b0;
				// write turnaround is 10, read turnaround is never driven
				tx_sr   <= {{sma_pre_len{1'b1}}, sma_start, tx_rdata.op, cfg.phyadr,
					tx_rdata.regad, 1'b1, tx_rdata.op == sma_op_read, tx_rdata.data};
			end
			else if (en)
			begin
				div_cnt <= tick ? '0 : div_cnt + 8'd1;
				if (tick)
					eth_mdc <= !eth_mdc;
				// second turnaround bit must come back 0
				if (mdc_rise && is_rd && (bit_cnt == 9'(ta_bit + 1)))
					ta_bad <= eth_mdio_i;
				if (mdc_fall)
				begin
					tx_sr   <= {tx_sr[sma_frame_len-2:0], 1'b0};
					bit_cnt <= bit_cnt + 9'd1;
					if (last_bit && is_rd)
					begin
						rx_push   <= !ta_bad && !rx_full;
						turn_nack <= ta_bad;
					end
					if (end_frame)
					begin
						en         <= 1'b0;
						frame_done <= 1'b1;
					end
				end
			end
		end
	end

	// read data sampled on mdc rise
	always_ff @(posedge ahb_hclk)
	begin
		if (mdc_rise && is_rd && in_frame && (bit_cnt >= 9'(data_bit)))
			rx_sr <= {rx_sr[14:0], eth_mdio_i};
	end

	// ==========================================================
	// pins
	// ==========================================================
	assign busy         = en;
	assign rx_wdata     = rx_sr;
	assign eth_mdc_oen  = !en;
	assign eth_mdio_o   = tx_sr[sma_frame_len-1];
	// released for read turnaround and data, and for the idle time
	assign eth_mdio_oen = !(en && in_frame && !(is_rd && (bit_cnt >= 9'(ta_bit))));

	// mdc parks low whenever the engine is idle
	a_mdc_idle_low: assert property (@(posedge ahb_hclk) disable iff (!ahb_hrstn)
		!busy |-> !eth_mdc);

endmodule

// ==== src/eth_sma_int_ctrl.sv ====
// status sets on a trigger rising edge only while enabled; a set wins over a same-cycle clear
module eth_sma_int_ctrl
(
	input  logic                                ahb_hclk,
	input  logic                                ahb_hrstn,
	input  logic [eth_sma_pkg::sma_cnt_w-1:0]   tx_cnt,
	input  logic [eth_sma_pkg::sma_cnt_w-1:0]   rx_cnt,
	input  eth_sma_pkg::sma_cfg_t               cfg,
	input  logic                                frame_done,
	input  logic                                turn_nack,
	input  eth_sma_pkg::sma_int_t               int_en,
	input  eth_sma_pkg::sma_int_t               int_clr,
	output eth_sma_pkg::sma_int_t               int_sta,
	output logic                                eth_sma_int_line
);

	import eth_sma_pkg::*;

	sma_int_t   tgr;
	logic [5:0] tgr_q;
	logic [5:0] pos;
	logic [5:0] sta_q;

	// ==========================================================
	// triggers
	// ==========================================================
	always_comb
	begin
		tgr.tx_warn    = tx_cnt <= cfg.tx_wm;
		tgr.tx_empty   = tx_cnt == '0;
		tgr.rx_warn    = rx_cnt >= cfg.rx_wm;
		tgr.rx_noempty = rx_cnt != '0;
		tgr.frame_done = frame_done;
		tgr.turn_nack  = turn_nack;
	end

	// previous trigger for the edge detect
	always_ff @(posedge ahb_hclk or negedge ahb_hrstn)
	begin
		if (!ahb_hrstn)
			tgr_q <= '0;
		else
			tgr_q <= tgr;
	end

	assign pos = tgr & ~tgr_q;

	// ==========================================================
	// sticky status
	// ==========================================================
	always_ff @(posedge ahb_hclk or negedge ahb_hrstn)
	begin
		if (!ahb_hrstn)
			sta_q <= '0;
		else
			sta_q <= (sta_q & ~int_clr) | (pos & int_en);
	end

	assign int_sta          = sma_int_t'(sta_q);
	assign eth_sma_int_line = |(sta_q & int_en);

endmodule

// ==== src/eth_sma_top.sv ====
// single clock MDIO master; FIFO_DEPTH at most 7 and applied to both FIFOs
module eth_sma_top
#(
	parameter int FIFO_DEPTH = 4
)
(
	input  logic        ahb_hclk,
	input  logic        ahb_hrstn,
	input  logic [31:0] paddr,
	input  logic        pwrite,
	input  logic        psel,
	input  logic        penable,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        eth_mdc,
	output logic        eth_mdc_oen,
	output logic        eth_mdio_o,
	input  logic        eth_mdio_i,
	output logic        eth_mdio_oen,
	output logic        eth_sma_int_line
);

	import eth_sma_pkg::*;

	logic                 tx_push;
	logic                 tx_pop;
	sma_cmd_t             tx_wdata;
	sma_cmd_t             tx_rdata;
	logic [sma_cnt_w-1:0] tx_cnt;
	logic                 rx_push;
	logic                 rx_pop;
	logic [15:0]          rx_wdata;
	logic [15:0]          rx_rdata;
	logic [sma_cnt_w-1:0] rx_cnt;
	logic                 rx_full;
	logic                 tx_clr;
	logic                 rx_clr;
	logic                 logic_clr;
	logic                 busy;
	logic                 frame_done;
	logic                 turn_nack;
	sma_cfg_t             cfg;
	sma_int_t             int_en;
	sma_int_t             int_clr;
	sma_int_t             int_sta;

	assign rx_full = rx_cnt == sma_cnt_w'(FIFO_DEPTH);

	// ==========================================================
	// register block and FIFOs
	// ==========================================================
	eth_sma_regs #(.FIFO_DEPTH(FIFO_DEPTH)) u_regs
	(
		.ahb_hclk  (ahb_hclk),   .ahb_hrstn (ahb_hrstn),
		.paddr     (paddr),      .pwrite    (pwrite),
		.psel      (psel),       .penable   (penable),
		.pwdata    (pwdata),     .prdata    (prdata),
		.tx_cnt    (tx_cnt),     .rx_cnt    (rx_cnt),
		.busy      (busy),       .rx_rdata  (rx_rdata),
		.int_sta   (int_sta),    .tx_push   (tx_push),
		.tx_wdata  (tx_wdata),   .rx_pop    (rx_pop),
		.tx_clr    (tx_clr),     .rx_clr    (rx_clr),
		.logic_clr (logic_clr),  .cfg       (cfg),
		.int_en    (int_en),     .int_clr   (int_clr)
	);

	eth_sma_fifo #(.DEPTH(FIFO_DEPTH), .WIDTH(23)) u_tx_fifo
	(
		.ahb_hclk (ahb_hclk), .ahb_hrstn (ahb_hrstn), .clr (tx_clr),
		.push (tx_push), .pop (tx_pop), .wdata (tx_wdata),
		.rdata (tx_rdata), .cnt (tx_cnt)
	);

	eth_sma_fifo #(.DEPTH(FIFO_DEPTH), .WIDTH(16)) u_rx_fifo
	(
		.ahb_hclk (ahb_hclk), .ahb_hrstn (ahb_hrstn), .clr (rx_clr),
		.push (rx_push), .pop (rx_pop), .wdata (rx_wdata),
		.rdata (rx_rdata), .cnt (rx_cnt)
	);

	// ==========================================================
	// frame engine and interrupts
	// ==========================================================
	eth_sma_engine u_engine
	(
		.ahb_hclk   (ahb_hclk),   .ahb_hrstn    (ahb_hrstn),
		.cfg        (cfg),        .logic_clr    (logic_clr),
		.tx_cnt     (tx_cnt),     .tx_rdata     (tx_rdata),
		.rx_full    (rx_full),    .eth_mdio_i   (eth_mdio_i),
		.tx_pop     (tx_pop),     .rx_push      (rx_push),
		.rx_wdata   (rx_wdata),   .busy         (busy),
		.frame_done (frame_done), .turn_nack    (turn_nack),
		.eth_mdc    (eth_mdc),    .eth_mdc_oen  (eth_mdc_oen),
		.eth_mdio_o (eth_mdio_o), .eth_mdio_oen (eth_mdio_oen)
	);

	eth_sma_int_ctrl u_int_ctrl
	(
		.ahb_hclk   (ahb_hclk),   .ahb_hrstn  (ahb_hrstn),
		.tx_cnt     (tx_cnt),     .rx_cnt     (rx_cnt),
		.cfg        (cfg),        .frame_done (frame_done),
		.turn_nack  (turn_nack),  .int_en     (int_en),
		.int_clr    (int_clr),    .int_sta    (int_sta),
		.eth_sma_int_line (eth_sma_int_line)
	);

endmodule

// ==== dv/eth_sma_tb.sv ====
// needs verilator timing; frame timeouts assume clkdiv 1 and interval 2 as written to cfg here
module eth_sma_tb;

	import eth_sma_pkg::*;

	// polls of int_sta before giving up on a frame
	localparam int frame_limit = 400;

	// clkdiv 1, phyadr 15, interval 2, tx_wm 1, rx_wm 2
	localparam logic [31:0] cfg_word = 32'h2102_1501;
	// rx_noempty, frame_done and turn_nack only
	localparam logic [31:0] en_word  = 32'h0000_0038;

	typedef struct packed
	{
		sma_op_e     op;
		logic [4:0]  regad;
		logic [15:0] data;
		logic        ta;
		logic        keep;
	} row_t;

	logic        ahb_hclk = 1'b0;
	logic        ahb_hrstn;
	logic [31:0] paddr;
	logic        pwrite;
	logic        psel;
	logic        penable;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        eth_mdc;
	logic        eth_mdc_oen;
	logic        eth_mdio_o;
	logic        eth_mdio_i;
	logic        eth_mdio_oen;
	logic        eth_sma_int_line;

	integer      seed;
	row_t        rows[$];
	string       names[$];
	row_t        cur_row;
	int          frame_id;
	int          seen_id;
	int          rise_n;
	int          cap_n;
	logic [63:0] cap_sr;
	int          rx_cnt_m;
	int          test_errs;
	int          pass_n;
	int          fail_n;
	string       cur_name;
	logic        timed_out;

	always #20 ahb_hclk = ~ahb_hclk;

	eth_sma_top #(.FIFO_DEPTH(4)) i_eth_sma_top
	(
		.ahb_hclk         (ahb_hclk),
		.ahb_hrstn        (ahb_hrstn),
		.paddr            (paddr),
		.pwrite           (pwrite),
		.psel             (psel),
		.penable          (penable),
		.pwdata           (pwdata),
		.prdata           (prdata),
		.eth_mdc          (eth_mdc),
		.eth_mdc_oen      (eth_mdc_oen),
		.eth_mdio_o       (eth_mdio_o),
		.eth_mdio_i       (eth_mdio_i),
		.eth_mdio_oen     (eth_mdio_oen),
		.eth_sma_int_line (eth_sma_int_line)
	);

	// ==========================================================
	// PHY responder
	// ==========================================================

	// bit the PHY puts on the line before rise k of the current frame
	function automatic logic phy_bit(input int k);
		logic [15:0] sh;
		phy_bit = 1'b1;
		if (cur_row.op == sma_op_read)
		begin
			if (k == 47)
				phy_bit = cur_row.ta;
			else if (k >= 48 && k < 64)
			begin
				sh = cur_row.data << (k - 48);
				phy_bit = sh[15];
			end
		end
	endfunction

	// capture whatever the master drives, restart on a new frame id
	initial
	begin
		seen_id = 0;
		rise_n  = 0;
		cap_n   = 0;
		cap_sr  = '0;
		forever
		begin
			@(posedge eth_mdc);
			if (seen_id != frame_id)
			begin
				seen_id = frame_id;
				rise_n  = 0;
				cap_n   = 0;
				cap_sr  = '0;
			end
			rise_n++;
			if (!eth_mdio_oen)
			begin
				cap_sr = {cap_sr[62:0], eth_mdio_o};
				cap_n++;
			end
		end
	end

	initial
	begin
		eth_mdio_i = 1'b1;
		forever
		begin
			@(negedge ahb_hclk);
			eth_mdio_i = phy_bit((seen_id == frame_id) ? rise_n : 0);
		end
	end

	// ==========================================================
	// bus access and checks
	// ==========================================================
	task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
		@(negedge ahb_hclk);
		paddr   = addr;
		pwdata  = data;
		pwrite  = 1'b1;
		psel    = 1'b1;
		penable = 1'b1;
		@(negedge ahb_hclk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	// prdata sampled mid low phase, before the edge that pops
	task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
		@(negedge ahb_hclk);
		paddr   = addr;
		pwrite  = 1'b0;
		psel    = 1'b1;
		penable = 1'b1;
		#5;
		data = prdata;
		@(negedge ahb_hclk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
		begin
			$display("FAIL %s expected %h actual %h", what, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_cmd(input string what, input sma_cmd_t exp, input sma_cmd_t act);
		if (exp !== act)
		begin
			$display("FAIL %s expected %h actual %h", what, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_int(input string what, input sma_int_t exp, input sma_int_t act);
		if (exp !== act)
		begin
			$display("FAIL %s expected %h actual %h", what, exp, act);
			test_errs++;
		end
	endtask

	// tx count is always 0 when this is read
	function automatic logic [31:0] stat_word(input logic busy_b, input int rx);
		stat_word = {23'b0, busy_b, 1'b0, 3'(rx), 4'b0000};
	endfunction

	task automatic start_test(input string name);
		cur_name  = name;
		test_errs = 0;
	endtask

	task automatic finish_test();
		if (test_errs == 0)
		begin
			$display("test %s ok", cur_name);
			pass_n++;
		end
		else
		begin
			$display("test %s failed with %0d errors", cur_name, test_errs);
			fail_n++;
		end
	endtask

	// bit 4 of int_sta is frame_done
	task automatic wait_frame(input string name, output logic done);
		logic [31:0] v;
		int          n;
		v = '0;
		n = 0;
		while ((v[4] !== 1'b1) && (n < frame_limit))
		begin
			bus_read(reg_int_sta, v);
			n++;
		end
		done = v[4] === 1'b1;
		if (!done)
			$display("timeout, frame done never set in %s", name);
	endtask

	// ==========================================================
	// stimulus table
	// ==========================================================
	task automatic add_row(input string name, input sma_op_e op, input logic [4:0] regad,
		input logic ta, input logic keep);
		row_t        r;
		logic [31:0] rnd;
		rnd     = $random(seed);
		r.op    = op;
		r.regad = regad;
		r.data  = rnd[15:0];
		r.ta    = ta;
		r.keep  = keep;
		rows.push_back(r);
		names.push_back(name);
	endtask

	task automatic load_table();
		add_row("wr_a", sma_op_write, 5'h03, 1'b0, 1'b0);
		add_row("wr_b", sma_op_write, 5'h1c, 1'b0, 1'b0);
		add_row("rd_ok", sma_op_read, 5'h02, 1'b0, 1'b0);
		add_row("rd_nack", sma_op_read, 5'h11, 1'b1, 1'b0);
		// these two leave their data in the rx FIFO
		add_row("rd_keep_a", sma_op_read, 5'h07, 1'b0, 1'b1);
		add_row("rd_keep_b", sma_op_read, 5'h0a, 1'b0, 1'b1);
	endtask

	task automatic run_row(input int i);
		row_t        r;
		string       n;
		logic        rd;
		logic        ok;
		logic [31:0] v;
		logic [63:0] ef;
		logic [63:0] f;
		sma_cmd_t    ec;
		sma_cmd_t    ac;
		sma_int_t    ei;
		r  = rows[i];
		n  = names[i];
		rd = r.op == sma_op_read;
		start_test(n);
		cur_row = r;
		frame_id++;
		bus_write(reg_txd, {9'b0, r.op, r.regad, r.data});
		bus_read(reg_stat, v);
		check_word({n, ".busy"}, stat_word(1'b1, rx_cnt_m), v);
		check_word({n, ".mdc_oen"}, 32'd0, {31'b0, eth_mdc_oen});
		wait_frame(n, ok);
		if (!ok)
		begin
			timed_out = 1'b1;
			test_errs++;
			finish_test();
			return;
		end
		check_word({n, ".mdc_oen_idle"}, 32'd1, {31'b0, eth_mdc_oen});
		if (rd && !r.ta)
			rx_cnt_m++;

		// expected line bits, turnaround and data left zero for a read
		if (rd)
			ef = {32'hffff_ffff, 2'b01, 2'b10, 5'h15, r.regad, 18'b0};
		else
			ef = {32'hffff_ffff, 2'b01, 2'b01, 5'h15, r.regad, 2'b10, r.data};
		f = cap_sr << (64 - cap_n);
		check_word({n, ".bits"}, rd ? 32'd46 : 32'd64, 32'(cap_n));
		check_word({n, ".pre"}, ef[63:32], f[63:32]);
		check_word({n, ".hdr"}, {23'b0, ef[31:30], ef[27:23], ef[17:16]},
			{23'b0, f[31:30], f[27:23], f[17:16]});

		ei            = '0;
		ei.frame_done = 1'b1;
		ei.turn_nack  = rd && r.ta;
		ei.rx_noempty = rx_cnt_m != 0;
		bus_read(reg_int_sta, v);
		check_int({n, ".sta"}, ei, sma_int_t'(v[5:0]));
		check_word({n, ".line"}, 32'd1, {31'b0, eth_sma_int_line});
		bus_write(reg_int_sta, 32'h30);
		ei.frame_done = 1'b0;
		ei.turn_nack  = 1'b0;
		bus_read(reg_int_sta, v);
		check_int({n, ".sta_clr"}, ei, sma_int_t'(v[5:0]));
		check_word({n, ".line_clr"}, {31'b0, ei.rx_noempty}, {31'b0, eth_sma_int_line});

		ec.op    = r.op;
		ec.regad = r.regad;
		ec.data  = r.data;
		ac       = sma_cmd_t'({f[29:28], f[22:18], f[15:0]});
		if (rd && r.keep)
		begin
			ec.data = '0;
			ac.data = '0;
		end
		else if (rd)
		begin
			// a nack frame pushes nothing, so the read finds an empty FIFO
			if (r.ta)
				ec.data = '0;
			bus_read(reg_rxd, v);
			ac.data = v[15:0];
			if (rx_cnt_m != 0)
				rx_cnt_m--;
			bus_write(reg_int_sta, 32'h08);
		end
		check_cmd({n, ".cmd"}, ec, ac);
		bus_read(reg_stat, v);
		check_word({n, ".stat"}, stat_word(1'b0, rx_cnt_m), v);
		finish_test();
	endtask

	// ==========================================================
	// main sequence
	// ==========================================================
	initial
	begin : stimulus
		logic [31:0] v;
		sma_int_t    ei;
		ahb_hrstn = 1'b0;
		paddr     = '0;
		pwrite    = 1'b0;
		psel      = 1'b0;
		penable   = 1'b0;
		pwdata    = '0;
		seed      = 32'hb2d8_e4f1;
		rx_cnt_m  = 0;
		pass_n    = 0;
		fail_n    = 0;
		timed_out = 1'b0;
		load_table();
		repeat (5) @(negedge ahb_hclk);
		ahb_hrstn = 1'b1;

		start_test("cfg_readback");
		// mdc low and both output enables off
		check_word("cfg_readback.pins", 32'h3, {29'b0, eth_mdc, eth_mdc_oen, eth_mdio_oen});
		bus_write(reg_cfg, cfg_word);
		bus_write(reg_int_en, en_word);
		bus_read(reg_cfg, v);
		check_word("cfg_readback.cfg", cfg_word, v);
		bus_read(reg_int_en, v);
		check_word("cfg_readback.int_en", en_word, v);
		bus_read(reg_int_sta, v);
		check_int("cfg_readback.sta", '0, sma_int_t'(v[5:0]));
		finish_test();

		for (int i = 0; (i < rows.size()) && !timed_out; i++)
			run_row(i);

		if (!timed_out)
		begin
			start_test("rx_clear");
			ei            = '0;
			ei.rx_noempty = 1'b1;
			bus_read(reg_int_sta, v);
			check_int("rx_clear.sta", ei, sma_int_t'(v[5:0]));
			bus_read(reg_stat, v);
			check_word("rx_clear.before", stat_word(1'b0, rx_cnt_m), v);
			bus_write(reg_ctrl, 32'h2);
			rx_cnt_m = 0;
			bus_read(reg_stat, v);
			check_word("rx_clear.after", stat_word(1'b0, rx_cnt_m), v);
			bus_read(reg_rxd, v);
			check_word("rx_clear.rxd", 32'h0, v);
			finish_test();
		end

		$display("tests passed %0d failed %0d", pass_n, fail_n);
		if (fail_n == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== eth_sma_top.f ====
src/eth_sma_pkg.sv
src/eth_sma_regs.sv
src/eth_sma_fifo.sv
src/eth_sma_engine.sv
src/eth_sma_int_ctrl.sv
src/eth_sma_top.sv
dv/eth_sma_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f eth_sma_top.f --top-module eth_sma_tb; then
	echo "verilator build failed"
	exit 1
fi

if ! out=$(./obj_dir/Veth_sma_tb); then
	printf '%s\n' "$out"
	echo "simulation exited with an error"
	exit 1
fi

printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
	exit 0
fi
exit 1
